// ==== hdl/game_pkg.sv ====
`default_nettype none

package game_pkg;

  // game flow, two bits wide so it packs into the status port
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    WIN  = 2'd2,
    OVER = 2'd3
  } state_t;

  // score value with its bcd digits, always registered together
  typedef struct packed {
    logic [6:0] value; // 0 to 99
    logic [3:0] tens;  // bcd tens digit
    logic [3:0] ones;  // bcd ones digit
  } score_t;

  // segment bits are g f e d c b a, msb first, lit segment is 1
  typedef struct packed {
    logic [6:0] tens_seg;
    logic [6:0] ones_seg;
  } seg_pair_t;

  localparam logic [6:0] SCORE_START       = 7'd10; // score after reset and in IDLE
  localparam logic [6:0] SCORE_MAX         = 7'd99; // winning score
  localparam logic [6:0] COLLISION_PENALTY = 7'd3;  // points lost per collision

  // 30 M cycles gives one tick every 2.5 s on the 12 MHz board
  localparam int unsigned TICK_DIV_DEFAULT = 30_000_000;
  localparam int unsigned TICK_W           = 26;

  localparam logic [6:0] SEG_BLANK = 7'h00; // all segments off

  // digit patterns indexed by the digit value
  localparam logic [6:0] SEG_PATTERN [10] = '{
    7'h3F, // 0
    7'h06, // 1
    7'h5B, // 2
    7'h4F, // 3
    7'h66, // 4
    7'h6D, // 5
    7'h7D, // 6
    7'h07, // 7
    7'h7F, // 8
    7'h6F  // 9
  };

endpackage

`default_nettype wire

// ==== hdl/tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
  parameter int unsigned tick_div = game_pkg::TICK_DIV_DEFAULT
) (
  input  logic clk,
  input  logic nRst_i,
  output logic tick
);

  import game_pkg::*;

  logic [TICK_W-1:0] count; // free running, wraps at tick_div - 1
  logic              wrap;

  assign wrap = (count == TICK_W'(tick_div - 1));

  // counts in every game state, the tick is a one cycle pulse on the wrap
  always_ff @(posedge clk, negedge nRst_i) begin
    if (!nRst_i) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (wrap) begin
      count <= '0;
      tick  <= 1'b1;
    end else begin
      count <= count + 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/game_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
  input  logic             clk,
  input  logic             nRst_i,
  input  logic             start,
  input  game_pkg::score_t score,
  output game_pkg::state_t state
);

  import game_pkg::*;

  state_t state_d;
  logic   at_max;  // score has reached the winning value
  logic   at_zero; // score has run out

  assign at_max  = (score.value == SCORE_MAX);
  assign at_zero = (score.value == 7'd0);

  always_comb begin
    state_d = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_d = RUN;
        end
      end
      RUN: begin
        // start is ignored while the game runs
        if (at_max) begin
          state_d = WIN;
        end else if (at_zero) begin
          state_d = OVER;
        end
      end
      WIN, OVER: begin
        if (start) begin
          state_d = IDLE; // back to the attract screen
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // terminal states show up one cycle after the terminal score
  always_ff @(posedge clk, negedge nRst_i) begin
    if (!nRst_i) begin
      state <= IDLE;
    end else begin
      state <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/score_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_counter (
  input  logic             clk,
  input  logic             nRst_i,
  input  logic             tick,
  input  logic             collision_detect,
  input  game_pkg::state_t state,
  output game_pkg::score_t score
);

  import game_pkg::*;

  logic              col_q;    // collision_detect one cycle ago
  logic              col_edge; // new collision this cycle
  logic signed [8:0] raw;      // unclamped score, may dip below zero
  logic        [6:0] value_d;
  logic        [6:0] tens_full;
  logic        [6:0] ones_full;
  score_t            score_d;

  assign col_edge = collision_detect & ~col_q;

  // only the rising edge counts, a held collision costs points once
  always_ff @(posedge clk, negedge nRst_i) begin
    if (!nRst_i) begin
      col_q <= 1'b0;
    end else begin
      col_q <= collision_detect;
    end
  end

  // tick and penalty together give a net change of minus two
  always_comb begin
    raw = $signed({2'b00, score.value});
    if (tick) begin
      raw = raw + 9'sd1;
    end
    if (col_edge) begin
      raw = raw - $signed({2'b00, COLLISION_PENALTY});
    end
  end

  always_comb begin
    value_d = score.value;
    case (state)
      IDLE: begin
        value_d = SCORE_START;
      end
      RUN: begin
        if (raw < 9'sd0) begin
          value_d = 7'd0; // clamp instead of wrapping
        end else if (raw > $signed({2'b00, SCORE_MAX})) begin
          value_d = SCORE_MAX;
        end else begin
          value_d = raw[6:0];
        end
      end
      WIN, OVER: begin
        value_d = score.value; // frozen until the next start
      end
      default: begin
        value_d = SCORE_START;
      end
    endcase
  end

  // one division by ten splits the value into its two digits
  assign tens_full = value_d / 7'd10;
  assign ones_full = value_d - (tens_full * 7'd10);

  assign score_d.value = value_d;
  assign score_d.tens  = tens_full[3:0];
  assign score_d.ones  = ones_full[3:0];

  always_ff @(posedge clk, negedge nRst_i) begin
    if (!nRst_i) begin
      score <= '{
        value: SCORE_START,
        tens:  4'(SCORE_START / 7'd10),
        ones:  4'(SCORE_START % 7'd10)
      };
    end else begin
      score <= score_d; // value and digits move in the same edge
    end
  end

endmodule

`default_nettype wire

// ==== hdl/score_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_display (
  input  game_pkg::state_t  state,
  input  game_pkg::score_t  score,
  output game_pkg::seg_pair_t digits
);

  import game_pkg::*;

  logic [3:0] tens_digit;
  logic [3:0] ones_digit;
  logic       blank_tens; // leading zero suppression

  // digits above nine never come from the counter, show them dark
  function automatic logic [6:0] seg_of(input logic [3:0] digit);
    logic [6:0] pattern;
    if (digit <= 4'd9) begin
      pattern = SEG_PATTERN[digit];
    end else begin
      pattern = SEG_BLANK;
    end
    return pattern;
  endfunction

  always_comb begin
    tens_digit = score.tens;
    ones_digit = score.ones;
    blank_tens = 1'b0;
    case (state)
      IDLE: begin
        // attract screen shows the start score with both digits
        blank_tens = 1'b0;
      end
      RUN, OVER: begin
        blank_tens = (score.tens == 4'd0); // over keeps the frozen score, steady
      end
      WIN: begin
        tens_digit = 4'd9; // fixed banner
        ones_digit = 4'd9;
      end
      default: begin
        blank_tens = 1'b0;
      end
    endcase
  end

  assign digits.tens_seg = blank_tens ? SEG_BLANK : seg_of(tens_digit);
  assign digits.ones_seg = seg_of(ones_digit);

endmodule

`default_nettype wire

// ==== hdl/score_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_top #(
  parameter int unsigned tick_div = game_pkg::TICK_DIV_DEFAULT
) (
  input  logic                clk,
  input  logic                nRst_i,
  input  logic                start,
  input  logic                collision_detect,
  output game_pkg::state_t    state,
  output game_pkg::score_t    score,
  output game_pkg::seg_pair_t digits
);

  logic tick; // slow game tick, one cycle wide

  tick_gen #(
    .tick_div(tick_div)
  ) u_tick_gen (
    .clk   (clk),
    .nRst_i(nRst_i),
    .tick  (tick)
  );

  // state and score are kept side by side and feed each other
  game_fsm u_game_fsm (
    .clk   (clk),
    .nRst_i(nRst_i),
    .start (start),
    .score (score),
    .state (state)
  );

  score_counter u_score_counter (
    .clk             (clk),
    .nRst_i          (nRst_i),
    .tick            (tick),
    .collision_detect(collision_detect),
    .state           (state),
    .score           (score)
  );

  score_display u_score_display (
    .state (state),
    .score (score),
    .digits(digits)
  );

endmodule

`default_nettype wire

// ==== sim/score_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_top_tb;

  import game_pkg::*;

  localparam int TICK_DIV = 16;
  // reset, tick count, collision, game over, win run with its frozen checks
  localparam int TEST_CYCLES = 48 + 6 * TICK_DIV + 8 * TICK_DIV + 80 + 104 * TICK_DIV;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

  logic        clk = 1'b0;
  logic        nRst_i;
  logic        start;
  logic        collision_detect;
  state_t      state;
  score_t      score;
  seg_pair_t   digits;

  state_t      exp_state; // reference model of the game
  int          exp_val;
  int          edge_no;   // clock edges since reset release
  logic        col_prev;
  int          errors       = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycles       = 0;

  score_top #(
    .tick_div(TICK_DIV)
  ) dut (
    .clk             (clk),
    .nRst_i          (nRst_i),
    .start           (start),
    .collision_detect(collision_detect),
    .state           (state),
    .score           (score),
    .digits          (digits)
  );

  always #5 clk = ~clk;

  // the score sees a tick on edge tick_div + 1, then every tick_div edges
  function automatic logic tick_seen(input int n);
    return (n > TICK_DIV) && ((n - 1) % TICK_DIV == 0);
  endfunction

  function automatic score_t make_score(input int v);
    score_t s;
    s.value = 7'(v);
    s.tens  = 4'(v / 10);
    s.ones  = 4'(v % 10);
    return s;
  endfunction

  function automatic seg_pair_t exp_digits(input state_t s, input int v);
    seg_pair_t d;
    if (s == WIN) begin
      d.tens_seg = SEG_PATTERN[9];
      d.ones_seg = SEG_PATTERN[9];
    end else begin
      d.tens_seg = SEG_PATTERN[v / 10];
      d.ones_seg = SEG_PATTERN[v % 10];
      if ((s == RUN || s == OVER) && v < 10) begin
        d.tens_seg = SEG_BLANK; // leading zero dark
      end
    end
    return d;
  endfunction

  always @(posedge clk) begin : model
    int   next_val;
    logic col_now;
    if (!nRst_i) begin
      exp_state <= IDLE;
      exp_val   <= int'(SCORE_START);
      edge_no   <= 0;
      col_prev  <= 1'b0;
    end else begin
      col_now  = collision_detect && !col_prev;
      next_val = exp_val + (tick_seen(edge_no + 1) ? 1 : 0);
      next_val = next_val - (col_now ? int'(COLLISION_PENALTY) : 0);
      edge_no  <= edge_no + 1;
      col_prev <= collision_detect;
      case (exp_state)
        IDLE: begin
          exp_val <= int'(SCORE_START);
          if (start) begin
            exp_state <= RUN;
          end
        end
        RUN: begin
          exp_val <= (next_val < 0) ? 0 : (next_val > 99) ? 99 : next_val;
          if (exp_val == 99) begin
            exp_state <= WIN;
          end else if (exp_val == 0) begin
            exp_state <= OVER;
          end
        end
        default: begin
          if (start) begin
            exp_state <= IDLE; // win and over keep the score until start
          end
        end
      endcase
    end
  end

  task automatic check_score(input string name, input score_t exp, input score_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %0d (%0d %0d) got %0d (%0d %0d)", $time, name,
               exp.value, exp.tens, exp.ones, act.value, act.tens, act.ones);
      errors++;
    end
  endtask

  task automatic check_state(input string name, input state_t exp, input state_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %s got %s", $time, name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic check_seg(input string name, input seg_pair_t exp, input seg_pair_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // advance on falling edges and compare everything with the model
  task automatic step(input int count);
    repeat (count) begin
      @(negedge clk);
      check_state("state", exp_state, state);
      check_score("score", make_score(exp_val), score);
      check_seg("digits", exp_digits(exp_state, exp_val), digits);
    end
  endtask

  task automatic pulse_start();
    start = 1'b1;
    step(1);
    start = 1'b0;
  endtask

  task automatic wait_state(input state_t target, input int limit);
    int n;
    n = 0;
    while (state !== target && n < limit) begin
      step(1);
      n++;
    end
    if (state !== target) begin
      $display("state never reached %s within %0d cycles", target.name(), limit);
      errors++;
    end
  endtask

  task automatic align_after_tick();
    int n;
    n = 0;
    while (!tick_seen(edge_no) && n <= TICK_DIV) begin
      step(1);
      n++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("%s done, no errors", name);
      tests_passed++;
    end else begin
      $display("%s done, %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  task automatic test_reset_idle();
    int e0;
    e0 = errors;
    check_state("state", IDLE, state);
    check_score("score", make_score(10), score);
    check_seg("digits", {SEG_PATTERN[1], SEG_PATTERN[0]}, digits);
    step(40); // two ticks pass in IDLE
    check_state("state", IDLE, state);
    check_score("score", make_score(10), score);
    check_seg("digits", {SEG_PATTERN[1], SEG_PATTERN[0]}, digits);
    report_test("test_reset_idle", e0);
  endtask

  task automatic test_tick_count();
    int e0;
    int prev;
    int n;
    e0 = errors;
    pulse_start();
    check_state("state", RUN, state);
    for (int k = 0; k < 5; k++) begin
      prev = exp_val;
      n    = 0;
      while (score.value == prev && n < 2 * TICK_DIV) begin
        step(1);
        n++;
      end
      if (score.value == prev) begin
        $display("no tick seen within %0d cycles", 2 * TICK_DIV);
        errors++;
      end
      check_score("score", make_score(prev + 1), score);
    end
    report_test("test_tick_count", e0);
  endtask

  task automatic test_collision();
    int e0;
    int prev;
    int gap;
    int n;
    e0 = errors;
    align_after_tick();
    prev             = exp_val;
    collision_detect = 1'b1; // held high, counts once
    step(6);
    collision_detect = 1'b0;
    step(1);
    check_score("score", make_score(prev - 3), score);
    for (int k = 0; k < 3; k++) begin
      align_after_tick();
      prev             = exp_val;
      gap              = 2 + ($urandom % 3);
      collision_detect = 1'b1;
      step(1);
      collision_detect = 1'b0;
      step(gap);
      check_score("score", make_score(prev - 3), score);
    end
    n = 0;
    while (!tick_seen(edge_no + 1) && n <= TICK_DIV) begin
      step(1);
      n++;
    end
    prev             = exp_val;
    collision_detect = 1'b1; // lands on the tick edge
    step(1);
    collision_detect = 1'b0;
    check_score("score", make_score(prev - 2), score);
    report_test("test_collision", e0);
  endtask

  task automatic test_game_over();
    int     e0;
    int     n;
    int     prev;
    score_t frozen;
    e0 = errors;
    n  = 0;
    while (state !== OVER && n < 40) begin
      prev             = exp_val;
      collision_detect = 1'b1;
      step(1);
      collision_detect = 1'b0;
      step(1);
      if (score.value > prev + 1) begin
        $display("score wrapped from %0d to %0d instead of clamping", prev, score.value);
        errors++;
      end
      n++;
    end
    check_state("state", OVER, state);
    frozen = make_score(exp_val);
    for (int k = 0; k < 3; k++) begin
      collision_detect = 1'b1;
      step(1);
      collision_detect = 1'b0;
      step(1);
    end
    step(2 * TICK_DIV);
    check_score("score", frozen, score);
    check_seg("digits", exp_digits(OVER, int'(frozen.value)), digits);
    report_test("test_game_over", e0);
  endtask

  task automatic test_win_restart();
    int e0;
    e0 = errors;
    pulse_start();
    step(1);
    check_state("state", IDLE, state);
    check_score("score", make_score(10), score);
    pulse_start();
    check_state("state", RUN, state);
    wait_state(WIN, 100 * TICK_DIV);
    check_score("score", make_score(99), score);
    check_seg("digits", {SEG_PATTERN[9], SEG_PATTERN[9]}, digits);
    step(2 * TICK_DIV);
    check_state("state", WIN, state);
    check_score("score", make_score(99), score);
    pulse_start();
    step(1);
    check_state("state", IDLE, state);
    check_score("score", make_score(10), score);
    check_seg("digits", {SEG_PATTERN[1], SEG_PATTERN[0]}, digits);
    report_test("test_win_restart", e0);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles, a test never finished", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    nRst_i           = 1'b0;
    start            = 1'b0;
    collision_detect = 1'b0;
    void'($urandom(39970)); // seeds the generator for the gaps
    repeat (5) @(posedge clk);
    @(negedge clk);
    nRst_i = 1'b1;
    test_reset_idle();
    test_tick_count();
    test_collision();
    test_game_over();
    test_win_restart();
    $display("tests passed %0d, tests failed %0d, value errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/game_pkg.sv
hdl/tick_gen.sv
hdl/game_fsm.sv
hdl/score_counter.sv
hdl/score_display.sv
hdl/score_top.sv
sim/score_top_tb.sv

// ==== Bender.yml ====
package:
  name: score_keeper

sources:
  - hdl/game_pkg.sv
  - hdl/tick_gen.sv
  - hdl/game_fsm.sv
  - hdl/score_counter.sv
  - hdl/score_display.sv
  - hdl/score_top.sv
  - target: simulation
    files:
      - sim/score_top_tb.sv
